//--- tb.f
design/eeprom_pkg.sv
design/i2c_byte_shifter.sv
design/eeprom_rw_ctrl.sv
design/eeprom_rw_top.sv
sim/eeprom_model.sv
sim/tb_eeprom_rw.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TB_TOP     ?= tb_eeprom_rw
RTL_TOP    ?= eeprom_rw_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 4
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_eeprom_rw.sv
`timescale 1ns/1ps
module tb_eeprom_rw;

    localparam int SCL_DIV     = 4;
    localparam int ADDR_W      = eeprom_pkg::ADDR_W;
    localparam int BLK_W       = ADDR_W - 8;
    localparam int MEM_BYTES   = 1 << ADDR_W;
    localparam int ACK_TIMEOUT = 4000;   // ack wait limit in cycles

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic [7:0]        rdata;
    logic              ack;
    logic              nack;
    logic              busy;
    logic              scl;
    logic              mismatch;
    wire               sda;

    logic [7:0]        sb [MEM_BYTES];       // expected memory contents
    logic              written [MEM_BYTES];
    logic [31:0]       rng;

    pullup (sda);

    eeprom_rw_top #(
        .SCL_DIV (SCL_DIV)
    ) UUT (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .busy  (busy),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model u_mem (
        .CLK      (CLK),
        .RESET    (RESET),
        .mismatch (mismatch),
        .scl      (scl),
        .sda      (sda)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // returns 1 ns into the ack cycle
    task automatic wait_ack(input string name);
        int cycles;
        cycles = 0;
        while (!ack && cycles < ACK_TIMEOUT)
        begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        if (!ack)
        begin
            $display("%s: no acknowledge arrived within %0d cycles", name, ACK_TIMEOUT);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    endtask

    task automatic do_write(input string name, input logic [ADDR_W-1:0] a,
                            input logic [7:0] d, output logic nk);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #1;
        wr    = 1'b0;
        addr  = ~a;   // already captured
        wdata = ~d;
        check({name, " busy"}, 1, busy);
        wait_ack(name);
        nk = nack;
    endtask

    task automatic do_read(input string name, input logic [ADDR_W-1:0] a,
                           output logic [7:0] d, output logic nk);
        rd   = 1'b1;
        addr = a;
        @(posedge CLK);
        #1;
        rd   = 1'b0;
        addr = ~a;
        check({name, " busy"}, 1, busy);
        wait_ack(name);
        d  = rdata;
        nk = nack;
    endtask

    task automatic write_tracked(input string name, input logic [ADDR_W-1:0] a,
                                 input logic [7:0] d);
        logic nk;
        do_write(name, a, d, nk);
        check({name, " nack"}, 0, nk);
        sb[a]      = d;
        written[a] = 1'b1;
    endtask

    task automatic after_reset();
        check("reset busy", 0, busy);
        check("reset ack", 0, ack);
        check("reset scl", 1, scl);
        check("reset sda", 1, sda);
    endtask

    task automatic single_write_read();
        logic [7:0] d;
        logic       nk;
        write_tracked("single write", 11'h123, 8'h5C);
        do_read("single read", 11'h123, d, nk);
        check("single read data", 8'h5C, d);
        check("single read nack", 0, nk);
    endtask

    task automatic random_write_read();
        logic [ADDR_W-1:0] used [$];
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic              nk;
        int                idx;
        for (int i = 0; i < 20; i++)
        begin
            rng = xorshift(rng);
            a   = {BLK_W'(i), rng[7:0]};   // block bits sweep all values
            write_tracked("random write", a, rng[15:8]);
            used.push_back(a);
        end
        for (int i = 0; i < 20; i++)
        begin
            rng = xorshift(rng);
            idx = int'(rng % 32'(used.size()));
            a   = used[idx];
            do_read("random read", a, d, nk);
            check("random read data", sb[a], d);
            check("random read nack", 0, nk);
        end
    endtask

    task automatic unwritten_read();
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic              nk;
        rng = xorshift(rng);
        a   = rng[ADDR_W-1:0];
        for (int t = 0; t < MEM_BYTES && written[a]; t++)
            a = a + 1'b1;   // next free address
        do_read("unwritten read", a, d, nk);
        check("unwritten read data", a[7:0], d);
        check("unwritten read nack", 0, nk);
    endtask

    task automatic no_ack_recovery();
        logic [7:0] d;
        logic       nk;
        mismatch = 1'b1;
        do_write("nack write", 11'h055, 8'hA5, nk);
        check("nack write nack", 1, nk);
        do_read("nack read", 11'h123, d, nk);
        check("nack read nack", 1, nk);
        mismatch = 1'b0;
        do_read("read after nack", 11'h123, d, nk);
        check("read after nack data", sb[11'h123], d);
        check("read after nack nack", 0, nk);
        do_read("nacked write address", 11'h055, d, nk);
        check("nacked write address data", sb[11'h055], d);
    endtask

    task automatic strobe_while_busy();
        logic [ADDR_W-1:0] b;
        logic [7:0]        d;
        logic              nk;
        int                extra;
        b    = 11'h3A7;
        rd   = 1'b1;
        addr = 11'h123;
        @(posedge CLK);
        #1;
        rd = 1'b0;
        for (int i = 0; i < 40; i++)
        begin
            @(posedge CLK);
            #1;
        end
        check("busy before stray wr", 1, busy);
        wr    = 1'b1;
        addr  = b;
        wdata = ~sb[b];
        @(posedge CLK);
        #1;
        wr = 1'b0;
        wait_ack("busy read");
        check("busy read data", sb[11'h123], rdata);
        check("busy read nack", 0, nack);
        extra = 0;
        for (int i = 0; i < 600; i++)
        begin
            @(posedge CLK);
            #1;
            if (ack || busy)
                extra++;
        end
        check("activity after busy read", 0, extra);
        do_read("stray write address", b, d, nk);
        check("stray write address data", sb[b], d);
    endtask

    initial
    begin
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wdata    = 8'h00;
        mismatch = 1'b0;
        rng      = 32'd76405;
        for (int i = 0; i < MEM_BYTES; i++)
        begin
            sb[i]      = 8'(i);
            written[i] = 1'b0;
        end
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(posedge CLK);
        #1;
        after_reset();
        single_write_read();
        random_write_read();
        unwritten_read();
        no_ack_recovery();
        strobe_while_busy();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- sim/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic mismatch,   // 1 ignores its own device address
    input  logic scl,
    inout  wire  sda
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } mstate_t;

    logic [7:0]                    mem [0:(1 << eeprom_pkg::ADDR_W) - 1];
    mstate_t                       st;
    logic [3:0]                    cnt;      // scl rises seen in this byte
    logic [7:0]                    shreg;
    logic [eeprom_pkg::ADDR_W-1:0] ptr;
    logic                          sda_oe;
    logic                          scl_q;
    logic                          sda_q;
    logic                          start;
    logic                          stop;
    logic                          rise;
    logic                          fall;

    assign sda = sda_oe ? 1'b0 : 1'bz;

    // lines are oversampled on CLK
    assign start = scl_q && scl && sda_q && !sda;
    assign stop  = scl_q && scl && !sda_q && sda;
    assign rise  = !scl_q && scl;
    assign fall  = scl_q && !scl;

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            st     <= M_IDLE;
            cnt    <= 4'd0;
            sda_oe <= 1'b0;
            ptr    <= '0;
            for (int i = 0; i < (1 << eeprom_pkg::ADDR_W); i++)
                mem[i] <= i[7:0];    // low address byte
        end
        else if (start)
        begin
            st     <= M_CTRL;
            cnt    <= 4'd0;
            sda_oe <= 1'b0;
        end
        else if (stop)
        begin
            st     <= M_IDLE;
            sda_oe <= 1'b0;
        end
        else if (st != M_IDLE)
        begin
            if (rise)
            begin
                if (cnt < 4'd8 && st != M_RDATA)
                    shreg <= {shreg[6:0], sda};
                cnt <= cnt + 4'd1;
            end
            else if (fall && cnt == 4'd8)
            begin
                // ninth slot
                case (st)
                    M_CTRL:
                        if (shreg[7:4] == eeprom_pkg::DEV_TYPE && !mismatch)
                            sda_oe <= 1'b1;
                        else
                            st <= M_IDLE;
                    M_ADDR, M_WDATA:
                        sda_oe <= 1'b1;
                    default:
                        sda_oe <= 1'b0;   // master answers a read byte
                endcase
            end
            else if (fall && cnt == 4'd9)
            begin
                cnt    <= 4'd0;
                sda_oe <= 1'b0;
                case (st)
                    M_CTRL:
                        if (shreg[0])
                        begin
                            st     <= M_RDATA;
                            shreg  <= mem[ptr];
                            sda_oe <= !mem[ptr][7];
                        end
                        else
                        begin
                            st <= M_ADDR;
                            ptr[eeprom_pkg::ADDR_W-1:8] <= shreg[eeprom_pkg::BLK_W:1];
                        end
                    M_ADDR:
                    begin
                        st       <= M_WDATA;
                        ptr[7:0] <= shreg;
                    end
                    M_WDATA:
                    begin
                        st       <= M_IDLE;   // single byte writes only
                        mem[ptr] <= shreg;
                    end
                    default:
                        st <= M_IDLE;
                endcase
            end
            else if (fall && st == M_RDATA)
            begin
                sda_oe <= !shreg[6];
                shreg  <= {shreg[6:0], 1'b0};
            end
        end
    end

endmodule

//--- design/eeprom_rw_top.sv
`timescale 1ns/1ps
module eeprom_rw_top #(
    parameter int SCL_DIV = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata,
    output logic                          ack,
    output logic                          nack,
    output logic                          busy,
    output logic                          scl,
    inout  wire                           sda
);

    eeprom_pkg::shift_cmd_t cmd;
    eeprom_pkg::shift_rsp_t rsp;
    logic                   cmd_valid;
    logic                   shift_busy;
    logic                   op_done;

    eeprom_rw_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .ack        (ack),
        .nack       (nack),
        .busy       (busy),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .shift_busy (shift_busy),
        .op_done    (op_done),
        .rsp        (rsp)
    );

    i2c_byte_shifter #(
        .SCL_DIV (SCL_DIV)
    ) u_shift (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .busy      (shift_busy),
        .op_done   (op_done),
        .rsp       (rsp),
        .scl       (scl),
        .sda       (sda)
    );

endmodule

//--- design/eeprom_rw_ctrl.sv
`timescale 1ns/1ps
module eeprom_rw_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata,
    output logic                          ack,
    output logic                          nack,
    output logic                          busy,
    output eeprom_pkg::shift_cmd_t        cmd,
    output logic                          cmd_valid,
    input  logic                          shift_busy,
    input  logic                          op_done,
    input  eeprom_pkg::shift_rsp_t        rsp
);

    typedef enum logic [9:0]
    {
        S_IDLE       = 10'b00_0000_0001,
        S_START      = 10'b00_0000_0010,
        S_CTRL_WRITE = 10'b00_0000_0100,
        S_ADDR_WRITE = 10'b00_0000_1000,
        S_DATA_WRITE = 10'b00_0001_0000,
        S_RESTART    = 10'b00_0010_0000,
        S_CTRL_READ  = 10'b00_0100_0000,
        S_DATA_READ  = 10'b00_1000_0000,
        S_STOP       = 10'b01_0000_0000,
        S_DONE       = 10'b10_0000_0000
    } state_t;

    state_t                        state;
    state_t                        state_n;
    logic                          pending;    // cmd waiting for the shifter
    logic                          issue;
    logic                          accept;
    logic                          is_read;
    logic                          wr_byte;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [7:0]                    wdata_q;
    eeprom_pkg::shift_cmd_t        next_cmd;

    function automatic logic [7:0] ctrl_byte(input logic [eeprom_pkg::BLK_W-1:0] blk,
                                             input logic rw);
        return {eeprom_pkg::DEV_TYPE, blk, rw};
    endfunction

    assign ack       = (state == S_DONE);
    assign busy      = !(state == S_IDLE || state == S_DONE);
    assign accept    = (state == S_IDLE || state == S_DONE) && (wr || rd);
    assign cmd_valid = pending && !shift_busy;

    // bytes that the slave has to acknowledge
    assign wr_byte = (state == S_CTRL_WRITE) || (state == S_ADDR_WRITE)
                     || (state == S_DATA_WRITE) || (state == S_CTRL_READ);

    always_comb
    begin
        state_n  = state;
        issue    = 1'b0;
        next_cmd = '{op: eeprom_pkg::OP_STOP, data: 8'h00};
        case (state)
            S_IDLE, S_DONE:
            begin
                state_n = S_IDLE;
                if (wr || rd)
                begin
                    state_n  = S_START;
                    issue    = 1'b1;
                    next_cmd = '{op: eeprom_pkg::OP_START, data: 8'h00};
                end
            end
            S_START:
                if (op_done)
                begin
                    state_n  = S_CTRL_WRITE;
                    issue    = 1'b1;
                    next_cmd = '{op: eeprom_pkg::OP_WRITE,
                                 data: ctrl_byte(addr_q[eeprom_pkg::ADDR_W-1:8],
                                                 eeprom_pkg::RW_WRITE)};
                end
            S_CTRL_WRITE:
                if (op_done)
                begin
                    state_n  = S_ADDR_WRITE;
                    issue    = 1'b1;
                    next_cmd = '{op: eeprom_pkg::OP_WRITE, data: addr_q[7:0]};
                end
            S_ADDR_WRITE:
                if (op_done)
                begin
                    issue = 1'b1;
                    if (is_read)
                    begin
                        state_n  = S_RESTART;    // random read turns the bus around
                        next_cmd = '{op: eeprom_pkg::OP_START, data: 8'h00};
                    end
                    else
                    begin
                        state_n  = S_DATA_WRITE;
                        next_cmd = '{op: eeprom_pkg::OP_WRITE, data: wdata_q};
                    end
                end
            S_RESTART:
                if (op_done)
                begin
                    state_n  = S_CTRL_READ;
                    issue    = 1'b1;
                    next_cmd = '{op: eeprom_pkg::OP_WRITE,
                                 data: ctrl_byte(addr_q[eeprom_pkg::ADDR_W-1:8],
                                                 eeprom_pkg::RW_READ)};
                end
            S_CTRL_READ:
                if (op_done)
                begin
                    state_n  = S_DATA_READ;
                    issue    = 1'b1;
                    next_cmd = '{op: eeprom_pkg::OP_READ, data: 8'h00};
                end
            S_DATA_WRITE, S_DATA_READ:
                if (op_done)
                begin
                    state_n = S_STOP;   // stop even after a nack
                    issue   = 1'b1;
                end
            S_STOP:
                if (op_done)
                    state_n = S_DONE;
            default:
                state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            pending <= 1'b0;
            nack    <= 1'b0;
        end
        else
        begin
            state <= state_n;
            if (issue)
                pending <= 1'b1;
            else if (cmd_valid)
                pending <= 1'b0;

            if (accept)
                nack <= 1'b0;
            else if (op_done && wr_byte)
                nack <= nack | !rsp.ack;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            is_read <= !wr;     // wr wins
        end
        if (issue)
            cmd <= next_cmd;
        if (op_done && state == S_DATA_READ)
            rdata <= rsp.data;
    end

endmodule

//--- design/i2c_byte_shifter.sv
`timescale 1ns/1ps
module i2c_byte_shifter #(
    parameter int SCL_DIV = 4     // CLK cycles per scl half period, 2 or more
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::shift_cmd_t cmd,
    input  logic                   cmd_valid,
    output logic                   busy,
    output logic                   op_done,
    output eeprom_pkg::shift_rsp_t rsp,
    output logic                   scl,
    inout  wire                    sda
);

    localparam int DIV_W     = $clog2(SCL_DIV);
    localparam int SAMPLE_AT = SCL_DIV / 2;    // middle of a high half

    eeprom_pkg::bus_op_t op;
    eeprom_pkg::bus_op_t enter_op;
    logic [DIV_W-1:0]    div_cnt;
    logic [4:0]          phase;          // half period index within the op
    logic [4:0]          last_phase;
    logic [4:0]          enter_phase;
    logic [7:0]          shreg;
    logic                ack_q;
    logic                sda_oe;         // 1 pulls sda low
    logic                accept;
    logic                step;
    logic                last;
    logic                enter;
    logic                tx_bit;
    logic                sample;

    // open drain, the pull-up sits outside
    assign sda = sda_oe ? 1'b0 : 1'bz;

    assign rsp = '{data: shreg, ack: ack_q};

    assign last_phase = (op == eeprom_pkg::OP_WRITE || op == eeprom_pkg::OP_READ)
                        ? eeprom_pkg::LAST_PH_BYTE : eeprom_pkg::LAST_PH_COND;

    assign accept = cmd_valid && !busy;
    assign step   = busy && (div_cnt == DIV_W'(SCL_DIV - 1));
    assign last   = (phase == last_phase);
    assign sample = busy && phase[0] && (div_cnt == DIV_W'(SAMPLE_AT));

    // half period about to begin
    assign enter       = accept || (step && !last);
    assign enter_phase = accept ? 5'd0 : phase + 5'd1;
    assign enter_op    = accept ? cmd.op : op;
    assign tx_bit      = accept ? cmd.data[7] : shreg[7];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            phase   <= 5'd0;
            div_cnt <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            if (accept)
            begin
                busy    <= 1'b1;
                phase   <= 5'd0;
                div_cnt <= '0;
            end
            else if (busy)
            begin
                if (step)
                begin
                    div_cnt <= '0;
                    if (last)
                    begin
                        busy    <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                        phase <= phase + 5'd1;
                end
                else
                    div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // line levels, changed only at the start of a half period
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end
        else if (enter)
        begin
            case (enter_op)
                eeprom_pkg::OP_START:
                    case (enter_phase)
                        5'd0:    sda_oe <= 1'b0;   // sda high first
                        5'd1:    scl <= 1'b1;
                        default: sda_oe <= 1'b1;   // falling sda with scl high
                    endcase
                eeprom_pkg::OP_STOP:
                    case (enter_phase)
                        5'd0:    sda_oe <= 1'b1;
                        5'd1:    scl <= 1'b1;
                        default: sda_oe <= 1'b0;   // rising sda with scl high
                    endcase
                default:
                begin
                    scl <= enter_phase[0];
                    // data moves only at the start of a low half
                    if (!enter_phase[0])
                        sda_oe <= (enter_op == eeprom_pkg::OP_WRITE)
                                  && (enter_phase != eeprom_pkg::ACK_PH_LOW)
                                  && !tx_bit;
                end
            endcase
        end
        else if (step && last && op != eeprom_pkg::OP_STOP)
            scl <= 1'b0;    // leave scl low between ops
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op    <= cmd.op;
            shreg <= cmd.data;
        end
        else if (op == eeprom_pkg::OP_WRITE && enter && enter_phase[0])
            shreg <= {shreg[6:0], 1'b0};   // next bit to msb while scl high
        else if (op == eeprom_pkg::OP_READ && sample && phase != eeprom_pkg::ACK_PH_HIGH)
            shreg <= {shreg[6:0], sda};

        if (sample && phase == eeprom_pkg::ACK_PH_HIGH)
            ack_q <= !sda;
    end

endmodule

//--- design/eeprom_pkg.sv
package eeprom_pkg;

    // two-wire bus operations; OP_START doubles as the repeated start
    typedef enum logic [2:0]
    {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bus_op_t;

    // controller -> shifter
    typedef struct packed
    {
        bus_op_t    op;
        logic [7:0] data;   // byte to send, only for OP_WRITE
    } shift_cmd_t;

    // shifter -> controller, valid with op_done
    typedef struct packed
    {
        logic [7:0] data;   // received byte after OP_READ
        logic       ack;    // slave pulled sda low in the ninth slot
    } shift_rsp_t;

    // byte address of the 2 Kbyte part
    localparam int ADDR_W = 11;

    // address bits above the low byte end up in the control byte
    localparam int BLK_W = ADDR_W - 8;

    // upper nibble of the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // r/w bit, lsb of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // number of half periods in each operation, minus one
    localparam logic [4:0] LAST_PH_BYTE = 5'd17;
    localparam logic [4:0] LAST_PH_COND = 5'd2;

    // ninth slot of a byte operation, ack or no-ack
    localparam logic [4:0] ACK_PH_LOW  = 5'd16;
    localparam logic [4:0] ACK_PH_HIGH = 5'd17;

endpackage
